/* chip_core.f */
+incdir+design
design/chip_pkg.sv
design/tag_master.sv
design/noc_repeater_node.sv
design/bypass_router.sv
design/bypass_endpoint.sv
design/chip_core.sv
tests/chip_core_assertions.sv
tests/chip_core_tb.sv

/* design/bypass_endpoint.sv */
`include "chip_defines.svh"

module bypass_endpoint
  (input  logic                    clk_i
  ,input  logic                    reset_i
  ,input  logic [`CHIP_DID_W-1:0]  core_did_i
  ,input  logic [`CHIP_DID_W-1:0]  host_did_i
  ,input  logic                    send_v_i
  ,input  logic [`CHIP_DATA_W-1:0] send_data_i
  ,output logic                    send_ready_o
  ,output chip_pkg::noc_link_s     router_link_o
  ,input  logic                    router_ready_i
  ,input  chip_pkg::noc_link_s     router_link_i
  ,output logic                    router_ready_o
  ,output chip_pkg::noc_link_s     recv_o
  ,input  logic                    recv_ready_i
  );

  logic                tx_v_r;
  logic                rx_v_r;
  chip_pkg::noc_flit_s tx_flit_r;
  chip_pkg::noc_flit_s rx_flit_r;

  // Both sides stay closed while the core is held in reset
  assign send_ready_o   = !reset_i && (!tx_v_r || router_ready_i);
  assign router_ready_o = !reset_i && (!rx_v_r || recv_ready_i);

  assign router_link_o = '{v: tx_v_r, flit: tx_flit_r};
  assign recv_o        = '{v: rx_v_r, flit: rx_flit_r};

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      tx_v_r  <= 1'b0;
      rx_v_r  <= 1'b0;
    end
    else
    begin
      if (send_v_i && send_ready_o)
        tx_v_r <= 1'b1;
      else if (router_ready_i)
        tx_v_r <= 1'b0;
      if (router_link_i.v && router_ready_o)
        rx_v_r <= 1'b1;
      else if (recv_ready_i)
        rx_v_r <= 1'b0;
    end
  end

  // Ids are stamped at acceptance
  always_ff @(posedge clk_i)
  begin
    if (send_v_i && send_ready_o)
      tx_flit_r <= '{dst: host_did_i, src: core_did_i, data: send_data_i};
    if (router_link_i.v && router_ready_o)
      rx_flit_r <= router_link_i.flit;
  end

endmodule

/* design/bypass_router.sv */
`include "chip_defines.svh"

module bypass_router
  (input  logic                                        clk_i
  ,input  logic                                        reset_i
  ,input  logic [`CHIP_DID_W-1:0]                      my_did_i
  ,input  chip_pkg::noc_link_s [`CHIP_NUM_PORTS-1:0]   link_i
  ,output logic [`CHIP_NUM_PORTS-1:0]                  ready_o
  ,output chip_pkg::noc_link_s [`CHIP_NUM_PORTS-1:0]   link_o
  ,input  logic [`CHIP_NUM_PORTS-1:0]                  ready_i
  );

  localparam int NP = `CHIP_NUM_PORTS;

  logic [1:0]          dir      [NP];
  logic [NP-1:0]       req      [NP];
  chip_pkg::noc_flit_s sel_flit [NP];
  chip_pkg::noc_flit_s out_flit_r [NP];
  logic [NP-1:0]       out_free;
  logic [NP-1:0]       out_v_r;

  ////////////////////////////////////////////////////////////////////////////
  // Route choice

  // Ids below ours go west, above go east, equal stays local
  always_comb
  begin
    for (int i = 0; i < NP; i++)
    begin
      if (link_i[i].flit.dst < my_did_i)
        dir[i] = 2'(`CHIP_PORT_W);
      else if (link_i[i].flit.dst > my_did_i)
        dir[i] = 2'(`CHIP_PORT_E);
      else
        dir[i] = 2'(`CHIP_PORT_P);
    end
  end

  // req[o][i] is input i asking for output o
  always_comb
  begin
    for (int o = 0; o < NP; o++)
    begin
      for (int i = 0; i < NP; i++)
        req[o][i] = link_i[i].v && (dir[i] == 2'(o));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration

  // Output register can take a flit when empty or draining
  always_comb
  begin
    for (int o = 0; o < NP; o++)
      out_free[o] = !out_v_r[o] || ready_i[o];
  end

  // Lower port index has priority: west, east, local
  always_comb
  begin
    for (int i = 0; i < NP; i++)
      ready_o[i] = out_free[dir[i]] && ((req[dir[i]] & NP'((1 << i) - 1)) == '0);
  end

  always_comb
  begin
    for (int o = 0; o < NP; o++)
    begin
      sel_flit[o] = link_i[`CHIP_PORT_W].flit;
      for (int i = NP - 1; i >= 0; i--)
      begin
        if (req[o][i])
          sel_flit[o] = link_i[i].flit;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output registers

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      out_v_r <= '0;
    else
    begin
      for (int o = 0; o < NP; o++)
      begin
        if (out_free[o])
          out_v_r[o] <= |req[o];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    for (int o = 0; o < NP; o++)
    begin
      if (out_free[o] && (|req[o]))
        out_flit_r[o] <= sel_flit[o];
    end
  end

  always_comb
  begin
    for (int o = 0; o < NP; o++)
      link_o[o] = '{v: out_v_r[o], flit: out_flit_r[o]};
  end

endmodule

/* design/chip_core.sv */
`include "chip_defines.svh"

module chip_core
  (input  logic                    clk_i
  ,input  logic                    reset_i

  ,input  chip_pkg::noc_link_s     west_link_i
  ,output logic                    west_ready_o
  ,output chip_pkg::noc_link_s     west_link_o
  ,input  logic                    west_ready_i

  ,input  chip_pkg::noc_link_s     east_link_i
  ,output logic                    east_ready_o
  ,output chip_pkg::noc_link_s     east_link_o
  ,input  logic                    east_ready_i

  ,input  logic                    send_v_i
  ,input  logic [`CHIP_DATA_W-1:0] send_data_i
  ,output logic                    send_ready_o

  ,output chip_pkg::noc_link_s     recv_o
  ,input  logic                    recv_ready_i

  ,input  logic                    tag_en_i
  ,input  logic                    tag_data_i
  );

  ////////////////////////////////////////////////////////////////////////////
  // Tag clients

  chip_pkg::tag_payload_s [`CHIP_TAG_CLIENTS-1:0] tag_payloads;
  logic                                           router_reset;
  logic                                           core_reset;

  tag_master btm
    (.clk_i      ( clk_i )
    ,.reset_i    ( reset_i )
    ,.tag_en_i   ( tag_en_i )
    ,.tag_data_i ( tag_data_i )
    ,.payloads_o ( tag_payloads )
    ,.new_o      ()
    );

  assign router_reset = reset_i | tag_payloads[chip_pkg::TAG_ROUTER].reset;
  assign core_reset   = reset_i | tag_payloads[chip_pkg::TAG_CORE].reset;

  ////////////////////////////////////////////////////////////////////////////
  // Bypass router and its link repeaters

  // _li feeds the router, _lo comes out of it
  wire chip_pkg::noc_link_s [`CHIP_NUM_PORTS-1:0] rtr_link_li;
  wire chip_pkg::noc_link_s [`CHIP_NUM_PORTS-1:0] rtr_link_lo;
  wire [`CHIP_NUM_PORTS-1:0]                      rtr_ready_li;
  wire [`CHIP_NUM_PORTS-1:0]                      rtr_ready_lo;

  noc_repeater_node west_repeater
    (.clk_i          ( clk_i )
    ,.reset_i        ( router_reset )
    ,.side_a_link_i  ( west_link_i )
    ,.side_a_link_o  ( west_link_o )
    ,.side_a_ready_i ( west_ready_i )
    ,.side_a_ready_o ( west_ready_o )
    ,.side_b_link_i  ( rtr_link_lo[`CHIP_PORT_W] )
    ,.side_b_link_o  ( rtr_link_li[`CHIP_PORT_W] )
    ,.side_b_ready_i ( rtr_ready_lo[`CHIP_PORT_W] )
    ,.side_b_ready_o ( rtr_ready_li[`CHIP_PORT_W] )
    );

  noc_repeater_node east_repeater
    (.clk_i          ( clk_i )
    ,.reset_i        ( router_reset )
    ,.side_a_link_i  ( east_link_i )
    ,.side_a_link_o  ( east_link_o )
    ,.side_a_ready_i ( east_ready_i )
    ,.side_a_ready_o ( east_ready_o )
    ,.side_b_link_i  ( rtr_link_lo[`CHIP_PORT_E] )
    ,.side_b_link_o  ( rtr_link_li[`CHIP_PORT_E] )
    ,.side_b_ready_i ( rtr_ready_lo[`CHIP_PORT_E] )
    ,.side_b_ready_o ( rtr_ready_li[`CHIP_PORT_E] )
    );

  bypass_router router
    (.clk_i    ( clk_i )
    ,.reset_i  ( router_reset )
    ,.my_did_i ( tag_payloads[chip_pkg::TAG_ROUTER].did )
    ,.link_i   ( rtr_link_li )
    ,.ready_o  ( rtr_ready_lo )
    ,.link_o   ( rtr_link_lo )
    ,.ready_i  ( rtr_ready_li )
    );

  ////////////////////////////////////////////////////////////////////////////
  // Local endpoint

  bypass_endpoint endpoint
    (.clk_i          ( clk_i )
    ,.reset_i        ( core_reset )
    ,.core_did_i     ( tag_payloads[chip_pkg::TAG_CORE].did )
    ,.host_did_i     ( tag_payloads[chip_pkg::TAG_HOST].did )
    ,.send_v_i       ( send_v_i )
    ,.send_data_i    ( send_data_i )
    ,.send_ready_o   ( send_ready_o )
    ,.router_link_o  ( rtr_link_li[`CHIP_PORT_P] )
    ,.router_ready_i ( rtr_ready_lo[`CHIP_PORT_P] )
    ,.router_link_i  ( rtr_link_lo[`CHIP_PORT_P] )
    ,.router_ready_o ( rtr_ready_li[`CHIP_PORT_P] )
    ,.recv_o         ( recv_o )
    ,.recv_ready_i   ( recv_ready_i )
    );

endmodule

/* design/chip_defines.svh */
`ifndef CHIP_DEFINES_SVH
`define CHIP_DEFINES_SVH

// Mesh flit fields
`define CHIP_DID_W 4
`define CHIP_DATA_W 16

// Router port indices
`define CHIP_NUM_PORTS 3
`define CHIP_PORT_W 0
`define CHIP_PORT_E 1
`define CHIP_PORT_P 2

// Tag frame layout, after the start bit: client id, then reset, then did
`define CHIP_TAG_ID_W 2
`define CHIP_TAG_CLIENTS 3
`define CHIP_TAG_PAYLOAD_W (1 + `CHIP_DID_W)
`define CHIP_TAG_FRAME_W (`CHIP_TAG_ID_W + `CHIP_TAG_PAYLOAD_W)

// Tag client ids
`define CHIP_TAG_ID_CORE 0
`define CHIP_TAG_ID_HOST 1
`define CHIP_TAG_ID_ROUTER 2

// Payload value held by every client out of reset
`define CHIP_TAG_PAYLOAD_DEFAULT {`CHIP_TAG_PAYLOAD_W{1'b0}}

`endif

/* design/chip_pkg.sv */
`include "chip_defines.svh"

package chip_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Mesh link types

  // Single-flit packet
  typedef struct packed
  {
    logic [`CHIP_DID_W-1:0]  dst;
    logic [`CHIP_DID_W-1:0]  src;
    logic [`CHIP_DATA_W-1:0] data;
  } noc_flit_s;

  // Sender side of a ready_and link, ready travels on its own wire
  typedef struct packed
  {
    logic      v;
    noc_flit_s flit;
  } noc_link_s;

  ////////////////////////////////////////////////////////////////////////////
  // Tag types

  typedef struct packed
  {
    logic                   reset;
    logic [`CHIP_DID_W-1:0] did;
  } tag_payload_s;

  typedef enum logic [`CHIP_TAG_ID_W-1:0]
  {
    TAG_CORE   = `CHIP_TAG_ID_W'(`CHIP_TAG_ID_CORE),
    TAG_HOST   = `CHIP_TAG_ID_W'(`CHIP_TAG_ID_HOST),
    TAG_ROUTER = `CHIP_TAG_ID_W'(`CHIP_TAG_ID_ROUTER)
  } tag_client_e;

endpackage

/* design/noc_repeater_node.sv */
module noc_repeater_node
  (input  logic                clk_i
  ,input  logic                reset_i
  ,input  chip_pkg::noc_link_s side_a_link_i
  ,output chip_pkg::noc_link_s side_a_link_o
  ,input  logic                side_a_ready_i
  ,output logic                side_a_ready_o
  ,input  chip_pkg::noc_link_s side_b_link_i
  ,output chip_pkg::noc_link_s side_b_link_o
  ,input  logic                side_b_ready_i
  ,output logic                side_b_ready_o
  );

  chip_pkg::noc_link_s in_link  [2];
  chip_pkg::noc_link_s out_link [2];
  logic [1:0]          in_ready;
  logic [1:0]          out_ready;

  // Direction 0 runs A to B, direction 1 runs B to A
  assign in_link[0]     = side_a_link_i;
  assign in_link[1]     = side_b_link_i;
  assign out_ready[0]   = side_b_ready_i;
  assign out_ready[1]   = side_a_ready_i;
  assign side_b_link_o  = out_link[0];
  assign side_a_link_o  = out_link[1];
  assign side_a_ready_o = in_ready[0];
  assign side_b_ready_o = in_ready[1];

  for (genvar d = 0; d < 2; d++)
  begin : dir
    chip_pkg::noc_flit_s mem_r [2];
    logic                wr_ptr_r;
    logic                rd_ptr_r;
    logic [1:0]          count_r;
    logic                enq;
    logic                deq;

    // Two entries keep ready registered at full rate
    assign in_ready[d] = (count_r != 2'd2);
    assign out_link[d] = '{v: (count_r != 2'd0), flit: mem_r[rd_ptr_r]};
    assign enq         = in_link[d].v & in_ready[d];
    assign deq         = out_link[d].v & out_ready[d];

    always_ff @(posedge clk_i)
    begin
      if (reset_i)
      begin
        wr_ptr_r <= 1'b0;
        rd_ptr_r <= 1'b0;
        count_r  <= 2'd0;
      end
      else
      begin
        wr_ptr_r <= wr_ptr_r ^ enq;
        rd_ptr_r <= rd_ptr_r ^ deq;
        count_r  <= count_r + {1'b0, enq} - {1'b0, deq};
      end
    end

    always_ff @(posedge clk_i)
    begin
      if (enq)
        mem_r[wr_ptr_r] <= in_link[d].flit;
    end
  end

endmodule

/* design/tag_master.sv */
`include "chip_defines.svh"

module tag_master
  (input  logic                                           clk_i
  ,input  logic                                           reset_i
  ,input  logic                                           tag_en_i
  ,input  logic                                           tag_data_i
  ,output chip_pkg::tag_payload_s [`CHIP_TAG_CLIENTS-1:0] payloads_o
  ,output logic [`CHIP_TAG_CLIENTS-1:0]                   new_o
  );

  localparam int CNT_W = $clog2(`CHIP_TAG_FRAME_W);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CHIP_TAG_FRAME_W - 1);

  logic                                           bit_li;
  logic                                           busy_r;
  logic [CNT_W-1:0]                               cnt_r;
  logic                                           done_r;
  logic [`CHIP_TAG_FRAME_W-1:0]                   shift_r;
  logic [`CHIP_TAG_ID_W-1:0]                      frame_id;
  chip_pkg::tag_payload_s                         frame_payload;
  chip_pkg::tag_payload_s [`CHIP_TAG_CLIENTS-1:0] payloads_r;
  logic [`CHIP_TAG_CLIENTS-1:0]                   new_r;

  // Line reads as 0 whenever it is not enabled
  assign bit_li = tag_en_i & tag_data_i;

  assign frame_id      = shift_r[`CHIP_TAG_FRAME_W-1 -: `CHIP_TAG_ID_W];
  assign frame_payload = shift_r[`CHIP_TAG_PAYLOAD_W-1:0];

  // Frame tracking, a 1 on an idle line starts a frame
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
      done_r <= 1'b0;
    end
    else
    begin
      done_r <= busy_r && (cnt_r == CNT_LAST);
      if (busy_r)
      begin
        cnt_r  <= cnt_r + 1'b1;
        busy_r <= (cnt_r != CNT_LAST);
      end
      else
      begin
        cnt_r  <= '0;
        busy_r <= bit_li;
      end
    end
  end

  // MSB first, so the client id ends up on top
  always_ff @(posedge clk_i)
  begin
    if (busy_r)
      shift_r <= {shift_r[`CHIP_TAG_FRAME_W-2:0], bit_li};
  end

  // Client registers, an unused id matches no client
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      payloads_r <= {`CHIP_TAG_CLIENTS{`CHIP_TAG_PAYLOAD_DEFAULT}};
      new_r      <= '0;
    end
    else
    begin
      for (int i = 0; i < `CHIP_TAG_CLIENTS; i++)
      begin
        new_r[i] <= done_r && (frame_id == `CHIP_TAG_ID_W'(i));
        if (done_r && (frame_id == `CHIP_TAG_ID_W'(i)))
          payloads_r[i] <= frame_payload;
      end
    end
  end

  assign payloads_o = payloads_r;
  assign new_o      = new_r;

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps --top-module chip_core_tb \
  -f chip_core.f -o Vchip_core_tb

output=$(./obj_dir/Vchip_core_tb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "Testbench passed"; then
  exit 0
fi
exit 1

/* tests/chip_core_assertions.sv */
module chip_core_assertions
  (input logic                clk_i
  ,input logic                reset_i
  ,input logic                router_reset_i
  ,input logic                core_reset_i
  ,input chip_pkg::noc_link_s west_out_link_i
  ,input logic                west_ready_i
  ,input chip_pkg::noc_link_s east_out_link_i
  ,input logic                east_ready_i
  ,input chip_pkg::noc_link_s recv_link_i
  ,input logic                recv_ready_i
  );

  timeunit 1ns;
  timeprecision 1ps;

  // A stalled flit holds until it is taken
  west_hold: assert property (@(posedge clk_i) disable iff (router_reset_i)
    west_out_link_i.v && !west_ready_i |=> west_out_link_i.v && $stable(west_out_link_i.flit))
    else $error("west link output changed while stalled");

  east_hold: assert property (@(posedge clk_i) disable iff (router_reset_i)
    east_out_link_i.v && !east_ready_i |=> east_out_link_i.v && $stable(east_out_link_i.flit))
    else $error("east link output changed while stalled");

  recv_hold: assert property (@(posedge clk_i) disable iff (core_reset_i)
    recv_link_i.v && !recv_ready_i |=> recv_link_i.v && $stable(recv_link_i.flit))
    else $error("recv output changed while stalled");

  // Endpoint stays quiet under the core reset
  recv_quiet: assert property (@(posedge clk_i) core_reset_i |=> !recv_link_i.v)
    else $error("recv valid high while the core reset is set");

  reset_clears: assert property (@(posedge clk_i)
    reset_i |=> !west_out_link_i.v && !east_out_link_i.v && !recv_link_i.v)
    else $error("a valid output was high in the cycle after reset");

endmodule

bind chip_core chip_core_assertions link_checks
  (.clk_i           ( clk_i )
  ,.reset_i         ( reset_i )
  ,.router_reset_i  ( router_reset )
  ,.core_reset_i    ( core_reset )
  ,.west_out_link_i ( west_link_o )
  ,.west_ready_i    ( west_ready_i )
  ,.east_out_link_i ( east_link_o )
  ,.east_ready_i    ( east_ready_i )
  ,.recv_link_i     ( recv_o )
  ,.recv_ready_i    ( recv_ready_i )
  );

/* tests/chip_core_tb.sv */
`include "chip_defines.svh"

module chip_core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 100;
  localparam int WEST    = 0;
  localparam int EAST    = 1;
  localparam int RECV    = 2;

  logic                    clk_i;
  logic                    reset_i;
  chip_pkg::noc_link_s     west_link_i;
  chip_pkg::noc_link_s     west_link_o;
  logic                    west_ready_i;
  logic                    west_ready_o;
  chip_pkg::noc_link_s     east_link_i;
  chip_pkg::noc_link_s     east_link_o;
  logic                    east_ready_i;
  logic                    east_ready_o;
  logic                    send_v_i;
  logic [`CHIP_DATA_W-1:0] send_data_i;
  logic                    send_ready_o;
  chip_pkg::noc_link_s     recv_o;
  logic                    recv_ready_i;
  logic                    tag_en_i;
  logic                    tag_data_i;

  chip_core dut_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and link helpers

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_flit(input string name, input chip_pkg::noc_flit_s exp,
                            input chip_pkg::noc_flit_s act);
    if (act !== exp)
      stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      stop_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_payload(input string name, input chip_pkg::tag_payload_s exp,
                               input chip_pkg::tag_payload_s act);
    if (act !== exp)
      stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
  endtask

  function automatic chip_pkg::noc_link_s out_link(input int port);
    case (port)
      WEST:    return west_link_o;
      EAST:    return east_link_o;
      default: return recv_o;
    endcase
  endfunction

  // Returns on the falling edge after the flit was taken
  task automatic take_flit(input int port, input string what,
                           output chip_pkg::noc_flit_s flit);
    chip_pkg::noc_link_s link;
    int                  n;
    n    = 0;
    link = out_link(port);
    while (!link.v)
    begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT)
        stop_run({what, " output never became valid"});
      link = out_link(port);
    end
    flit = link.flit;
    @(negedge clk_i);
  endtask

  task automatic put_flit(input int port, input chip_pkg::noc_flit_s flit);
    int n;
    n = 0;
    if (port == WEST)
      west_link_i = '{v: 1'b1, flit: flit};
    else
      east_link_i = '{v: 1'b1, flit: flit};
    while (!((port == WEST) ? west_ready_o : east_ready_o))
    begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT)
        stop_run("link input never became ready");
    end
    @(negedge clk_i);
    if (port == WEST)
      west_link_i.v = 1'b0;
    else
      east_link_i.v = 1'b0;
  endtask

  task automatic send_local(input logic [`CHIP_DATA_W-1:0] data);
    int n;
    n           = 0;
    send_v_i    = 1'b1;
    send_data_i = data;
    while (!send_ready_o)
    begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT)
        stop_run("local send side never became ready");
    end
    @(negedge clk_i);
    send_v_i = 1'b0;
  endtask

  // Start bit, client id, then payload, MSB first
  task automatic send_tag_frame(input logic [1:0] id, input chip_pkg::tag_payload_s payload);
    logic [`CHIP_TAG_FRAME_W:0] bits;
    bits     = {1'b1, id, payload};
    tag_en_i = 1'b1;
    for (int i = `CHIP_TAG_FRAME_W; i >= 0; i--)
    begin
      tag_data_i = bits[i];
      @(negedge clk_i);
    end
    tag_data_i = 1'b0;
    tag_en_i   = 1'b0;
    // Payload and the resets it drives settle within two cycles
    repeat (2) @(negedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic test_reset_state();
    chip_pkg::noc_flit_s     got;
    logic [`CHIP_DATA_W-1:0] data;
    data = `CHIP_DATA_W'($urandom);
    check_bit("reset_state west valid", 1'b0, west_link_o.v);
    check_bit("reset_state east valid", 1'b0, east_link_o.v);
    check_bit("reset_state recv valid", 1'b0, recv_o.v);
    check_bit("reset_state send ready", 1'b1, send_ready_o);
    check_bit("reset_state west ready", 1'b1, west_ready_o);
    check_bit("reset_state east ready", 1'b1, east_ready_o);
    send_local(data);
    take_flit(RECV, "recv", got);
    check_flit("reset_state local send", '{dst: '0, src: '0, data: data}, got);
  endtask

  task automatic test_tag_send();
    logic [`CHIP_DATA_W-1:0] data;
    data = `CHIP_DATA_W'($urandom);
    send_tag_frame(chip_pkg::TAG_ROUTER, '{reset: 1'b0, did: 4'd5});
    send_tag_frame(chip_pkg::TAG_HOST, '{reset: 1'b0, did: 4'd2});
    send_tag_frame(chip_pkg::TAG_CORE, '{reset: 1'b0, did: 4'd5});
    send_tag_frame(2'd3, '{reset: 1'b1, did: 4'hf});
    check_payload("tag_send core", '{1'b0, 4'd5}, dut_i.tag_payloads[chip_pkg::TAG_CORE]);
    check_payload("tag_send host", '{1'b0, 4'd2}, dut_i.tag_payloads[chip_pkg::TAG_HOST]);
    check_payload("tag_send router", '{1'b0, 4'd5}, dut_i.tag_payloads[chip_pkg::TAG_ROUTER]);
    send_local(data);
    // Endpoint, router, repeater
    for (int c = 1; c <= 3; c++)
    begin
      check_bit($sformatf("tag_send west valid cycle %0d", c), c == 3, west_link_o.v);
      if (c < 3)
        @(negedge clk_i);
    end
    check_flit("tag_send west flit", '{dst: 4'd2, src: 4'd5, data: data}, west_link_o.flit);
    @(negedge clk_i);
  endtask

  task automatic test_link_routing();
    chip_pkg::noc_flit_s f;
    chip_pkg::noc_flit_s got;
    f = '{dst: 4'd5, src: 4'd3, data: `CHIP_DATA_W'($urandom)};
    put_flit(WEST, f);
    take_flit(RECV, "recv", got);
    check_flit("link_routing west to local", f, got);
    f = '{dst: 4'd9, src: 4'd3, data: `CHIP_DATA_W'($urandom)};
    put_flit(WEST, f);
    take_flit(EAST, "east", got);
    check_flit("link_routing west to east", f, got);
    f = '{dst: 4'd1, src: 4'd8, data: `CHIP_DATA_W'($urandom)};
    put_flit(EAST, f);
    take_flit(WEST, "west", got);
    check_flit("link_routing east to west", f, got);
  endtask

  task automatic test_back_pressure();
    chip_pkg::noc_flit_s sent [6];
    chip_pkg::noc_flit_s got;
    for (int i = 0; i < 6; i++)
      sent[i] = '{dst: 4'(6 + $urandom % 10), src: 4'd3, data: `CHIP_DATA_W'($urandom)};
    east_ready_i = 1'b0;
    fork
      begin
        for (int i = 0; i < 5; i++)
          put_flit(WEST, sent[i]);
        // Two repeaters and the router register hold five flits
        check_bit("back_pressure west ready", 1'b0, west_ready_o);
        put_flit(WEST, sent[5]);
      end
      begin
        repeat (12) @(negedge clk_i);
        east_ready_i = 1'b1;
        for (int i = 0; i < 6; i++)
        begin
          take_flit(EAST, "east", got);
          check_flit($sformatf("back_pressure flit %0d", i), sent[i], got);
        end
      end
    join
  endtask

  task automatic test_core_reset();
    chip_pkg::noc_flit_s f;
    chip_pkg::noc_flit_s got;
    f = '{dst: 4'd5, src: 4'd9, data: `CHIP_DATA_W'($urandom)};
    send_tag_frame(chip_pkg::TAG_CORE, '{reset: 1'b1, did: 4'd5});
    check_bit("core_reset send ready", 1'b0, send_ready_o);
    put_flit(WEST, f);
    repeat (8)
    begin
      @(negedge clk_i);
      check_bit("core_reset recv valid", 1'b0, recv_o.v);
    end
    send_tag_frame(chip_pkg::TAG_CORE, '{reset: 1'b0, did: 4'd5});
    check_bit("core_reset send ready released", 1'b1, send_ready_o);
    take_flit(RECV, "recv", got);
    check_flit("core_reset held flit", f, got);
  endtask

  task automatic test_contention();
    chip_pkg::noc_flit_s fw;
    chip_pkg::noc_flit_s fe;
    chip_pkg::noc_flit_s got0;
    chip_pkg::noc_flit_s got1;
    fw = '{dst: 4'd5, src: 4'd1, data: `CHIP_DATA_W'($urandom)};
    fe = '{dst: 4'd5, src: 4'd12, data: `CHIP_DATA_W'($urandom)};
    fork
      put_flit(WEST, fw);
      put_flit(EAST, fe);
    join
    take_flit(RECV, "recv", got0);
    take_flit(RECV, "recv", got1);
    // Either order is fine
    if (got0 == fe)
    begin
      got0 = got1;
      got1 = fe;
    end
    check_flit("contention west flit", fw, got0);
    check_flit("contention east flit", fe, got1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence

  initial
  begin
    void'($urandom(32'h60639980));
    reset_i      = 1'b1;
    west_link_i  = '0;
    east_link_i  = '0;
    west_ready_i = 1'b1;
    east_ready_i = 1'b1;
    recv_ready_i = 1'b1;
    send_v_i     = 1'b0;
    send_data_i  = '0;
    tag_en_i     = 1'b0;
    tag_data_i   = 1'b0;
    repeat (3) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    test_reset_state();
    test_tag_send();
    test_link_routing();
    test_back_pressure();
    test_core_reset();
    test_contention();
    $display("Testbench passed");
    $finish;
  end

endmodule
